/* filelist.f */
hdl/pext_mult_pkg.sv
hdl/pext_mult_seq.sv
hdl/pext_mult_operands.sv
hdl/pext_mult_kernel.sv
hdl/pext_mult_result.sv
hdl/pext_mult_top.sv
testbench/tb_clk_gen.sv
testbench/pext_mult_sva.sv
testbench/tb_pext_mult.sv

/* hdl/pext_mult_kernel.sv */
////////////////////
// Baugh-Wooley kernel array
// Eight 9x9 lane multipliers, 16x16 and 32x16 kernel adders
////////////////////
`timescale 1ns/100ps
`default_nettype none

module pext_mult_kernel import pext_mult_pkg::*; (
  input  ker_operands_t ker_i,
  output ker_sums_t     sums_o
);

  lane_prod_t [3:0]   diag_prod;
  data_t      [1:0]   half_prod;
  logic signed [33:0] ker_sum [2];
  logic signed [47:0] ker_lo_ext;
  logic signed [47:0] ker_hi_ext;

  ////////////////////
  // 16x16 kernels
  ////////////////////
  // Kernel k covers byte lanes 2k and 2k+1 of both operands
  for (genvar k = 0; k < 2; k++) begin : g_ker
    logic signed [8:0]  a_lo, a_hi, b_lo, b_hi;
    logic signed [17:0] p00, p01, p10, p11;
    logic signed [33:0] e00, e01, e10, e11;

    // Sign bit from the decoder extends each byte to 9 bits
    assign a_lo = {ker_i.a_sign[2*k],   ker_i.a[2*k]};
    assign a_hi = {ker_i.a_sign[2*k+1], ker_i.a[2*k+1]};
    assign b_lo = {ker_i.b_sign[2*k],   ker_i.b[2*k]};
    assign b_hi = {ker_i.b_sign[2*k+1], ker_i.b[2*k+1]};

    assign p00 = a_lo * b_lo;
    assign p01 = a_lo * b_hi;
    assign p10 = a_hi * b_lo;
    assign p11 = a_hi * b_hi;

    assign e00 = p00;
    assign e01 = p01;
    assign e10 = p10;
    assign e11 = p11;

    // Partial products weighted by byte position
    assign ker_sum[k] = (e11 <<< 16) + ((e01 + e10) <<< 8) + e00;

    assign diag_prod[2*k]   = p00;
    assign diag_prod[2*k+1] = p11;
    assign half_prod[k]     = ker_sum[k][31:0];
  end

  ////////////////////
  // 32x16 adder
  ////////////////////
  // Upper kernel carries A[31:16], lower one the unsigned A[15:0]
  assign ker_lo_ext = ker_sum[0];
  assign ker_hi_ext = ker_sum[1];

  assign sums_o.diag      = diag_prod;
  assign sums_o.prod16    = half_prod;
  assign sums_o.prod32x16 = (ker_hi_ext <<< 16) + ker_lo_ext;

endmodule

`default_nettype wire

/* hdl/pext_mult_operands.sv */
////////////////////
// Kernel operand selector
// Quadrant choice of B bytes and sign bit decode
////////////////////
`timescale 1ns/100ps
`default_nettype none

module pext_mult_operands import pext_mult_pkg::*; (
  input  data_t         op_a_i,
  input  data_t         op_b_i,
  input  mult_mode_e    mode_i,
  input  mult_state_e   state_i,
  output ker_operands_t ker_o
);

  lane_t [3:0] a_bytes;
  lane_t [3:0] b_bytes;
  half_t       b_half;
  logic  [3:0] a_sign;
  logic  [3:0] b_sign;

  assign a_bytes = op_a_i;

  // B half feeding both kernel pairs in 32x16 mode
  assign b_half = (state_i == UPPER) ? op_b_i[31:16] : op_b_i[15:0];

  always_comb begin
    if (mode_i == M32X16) begin
      b_bytes = {b_half, b_half};
    end else begin
      b_bytes = op_b_i;
    end
  end

  ////////////////////
  // Sign decoder
  ////////////////////
  // Low bytes of a wide operand are unsigned and get a zero sign
  always_comb begin
    unique case (mode_i)
      M8X8: begin
        a_sign = {a_bytes[3][7], a_bytes[2][7], a_bytes[1][7], a_bytes[0][7]};
        b_sign = {b_bytes[3][7], b_bytes[2][7], b_bytes[1][7], b_bytes[0][7]};
      end
      M16X16: begin
        a_sign = {a_bytes[3][7], 1'b0, a_bytes[1][7], 1'b0};
        b_sign = {b_bytes[3][7], 1'b0, b_bytes[1][7], 1'b0};
      end
      M32X16: begin
        a_sign = {a_bytes[3][7], 3'b000};
        // Low half of B is the unsigned part of the 32x32 product
        if (state_i == UPPER) begin
          b_sign = {b_half[15], 1'b0, b_half[15], 1'b0};
        end else begin
          b_sign = 4'b0000;
        end
      end
      default: begin
        a_sign = 4'b0000;
        b_sign = 4'b0000;
      end
    endcase
  end

  assign ker_o.a      = a_bytes;
  assign ker_o.b      = b_bytes;
  assign ker_o.a_sign = a_sign;
  assign ker_o.b_sign = b_sign;

endmodule

`default_nettype wire

/* hdl/pext_mult_pkg.sv */
////////////////////
// Shared types of the packed-SIMD multiplier
// Word, lane and product types, opcode and mode enums, datapath structs
////////////////////
`default_nettype none

package pext_mult_pkg;

  // Plain vector types
  typedef logic [31:0] data_t;
  typedef logic [7:0]  lane_t;
  typedef logic [15:0] half_t;
  typedef logic [17:0] lane_prod_t;
  typedef logic [47:0] prod48_t;

  // Supported operations
  typedef enum logic [2:0] {
    OP_KHM8   = 3'd0,
    OP_KHM16  = 3'd1,
    OP_SMBB16 = 3'd2,
    OP_SMTT16 = 3'd3,
    OP_MUL    = 3'd4,
    OP_MULH   = 3'd5
  } pext_op_e;

  // Kernel arrangement
  typedef enum logic [1:0] {
    M8X8   = 2'd0,
    M16X16 = 2'd1,
    M32X16 = 2'd2
  } mult_mode_e;

  typedef enum logic {
    LOWER = 1'b0,
    UPPER = 1'b1
  } mult_state_e;

  // Operands of the eight lane multipliers, index is the byte lane
  typedef struct packed {
    lane_t [3:0] a;
    lane_t [3:0] b;
    logic  [3:0] a_sign;
    logic  [3:0] b_sign;
  } ker_operands_t;

  typedef struct packed {
    lane_prod_t [3:0] diag;
    data_t      [1:0] prod16;
    prod48_t          prod32x16;
  } ker_sums_t;

endpackage

`default_nettype wire

/* hdl/pext_mult_result.sv */
////////////////////
// Result stage
// 32x32 combining adder, saturation detect, result mux
////////////////////
`timescale 1ns/100ps
`default_nettype none

module pext_mult_result import pext_mult_pkg::*; (
  input  pext_op_e    op_i,
  input  mult_state_e state_i,
  input  ker_sums_t   sums_i,
  input  prod48_t     imd_i,
  input  logic        valid_i,
  output data_t       result_o,
  output logic        set_ov_o
);

  logic signed [63:0] cur_ext;
  logic signed [63:0] imd_ext;
  logic signed [63:0] full_prod;
  logic        [3:0]  sat8;
  logic        [1:0]  sat16;
  lane_t       [3:0]  khm8_res;
  half_t       [1:0]  khm16_res;
  logic               sat_hit;

  // Full product = A*B[31:16] shifted up plus stored A*B[15:0]
  assign cur_ext = $signed(sums_i.prod32x16);

  always_comb begin
    imd_ext = 64'sd0;
    if (state_i == UPPER) begin
      imd_ext = $signed(imd_i);
    end
  end

  assign full_prod = (cur_ext <<< 16) + imd_ext;

  ////////////////////
  // Q7 and Q15 lanes
  ////////////////////
  // Only -1 * -1 reaches these products
  for (genvar i = 0; i < 4; i++) begin : g_q7
    assign sat8[i]     = (sums_i.diag[i] == 18'h0_4000);
    assign khm8_res[i] = sat8[i] ? 8'h7f : sums_i.diag[i][14:7];
  end

  for (genvar j = 0; j < 2; j++) begin : g_q15
    assign sat16[j]     = (sums_i.prod16[j] == 32'h4000_0000);
    assign khm16_res[j] = sat16[j] ? 16'h7fff : sums_i.prod16[j][30:15];
  end

  // Final mux
  always_comb begin
    sat_hit = 1'b0;
    unique case (op_i)
      OP_KHM8: begin
        result_o = khm8_res;
        sat_hit  = |sat8;
      end
      OP_KHM16: begin
        result_o = khm16_res;
        sat_hit  = |sat16;
      end
      OP_SMBB16: result_o = sums_i.prod16[0];
      OP_SMTT16: result_o = sums_i.prod16[1];
      OP_MUL:    result_o = full_prod[31:0];
      OP_MULH:   result_o = full_prod[63:32];
      default:   result_o = '0;
    endcase
  end

  assign set_ov_o = valid_i & sat_hit;

endmodule

`default_nettype wire

/* hdl/pext_mult_seq.sv */
////////////////////
// Multiplier sequencer
// Mode decode, LOWER/UPPER FSM, intermediate product register
////////////////////
`timescale 1ns/100ps
`default_nettype none

module pext_mult_seq import pext_mult_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  pext_op_e    op_i,
  input  ker_sums_t   sums_i,
  input  logic        ready_i,
  output mult_mode_e  mode_o,
  output mult_state_e state_o,
  output prod48_t     imd_o,
  output logic        valid_o
);

  mult_state_e state_q, state_d;
  prod48_t     imd_q;
  logic        two_cycle;
  logic        imd_we;

  // Operation to kernel arrangement
  always_comb begin
    unique case (op_i)
      OP_KHM8:                      mode_o = M8X8;
      OP_KHM16, OP_SMBB16, OP_SMTT16: mode_o = M16X16;
      OP_MUL, OP_MULH:              mode_o = M32X16;
      default:                      mode_o = M8X8;
    endcase
  end

  // Only the 32x32 products need a second pass
  assign two_cycle = (mode_o == M32X16);

  always_comb begin
    state_d = state_q;
    valid_o = 1'b0;
    imd_we  = 1'b0;
    unique case (state_q)
      LOWER: begin
        valid_o = req_i & ~two_cycle;
        if (req_i && two_cycle) begin
          imd_we  = 1'b1;
          state_d = UPPER;
        end
      end
      UPPER: begin
        valid_o = req_i;
        // Hold until the consumer takes it, or the request goes away
        if (ready_i || !req_i) begin
          state_d = LOWER;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LOWER;
      imd_q   <= '0;
    end else begin
      state_q <= state_d;
      if (imd_we) begin
        imd_q <= sums_i.prod32x16;
      end
    end
  end

  assign state_o = state_q;
  assign imd_o   = imd_q;

endmodule

`default_nettype wire

/* hdl/pext_mult_top.sv */
////////////////////
// Packed-SIMD signed multiplier top level
// Sequencer, operand selector, kernel array and result stage
////////////////////
`timescale 1ns/100ps
`default_nettype none

module pext_mult_top import pext_mult_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     req_i,
  input  pext_op_e op_i,
  input  data_t    op_a_i,
  input  data_t    op_b_i,
  input  logic     ready_i,

  output logic     valid_o,
  output data_t    result_o,
  output logic     set_ov_o
);

  mult_mode_e    mult_mode;
  mult_state_e   state;
  prod48_t       imd_q;
  ker_operands_t ker_ops;
  ker_sums_t     ker_sums;

  pext_mult_seq u_seq (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .op_i    (op_i),
    .sums_i  (ker_sums),
    .ready_i (ready_i),
    .mode_o  (mult_mode),
    .state_o (state),
    .imd_o   (imd_q),
    .valid_o (valid_o)
  );

  pext_mult_operands u_operands (
    .op_a_i  (op_a_i),
    .op_b_i  (op_b_i),
    .mode_i  (mult_mode),
    .state_i (state),
    .ker_o   (ker_ops)
  );

  pext_mult_kernel u_kernel (
    .ker_i  (ker_ops),
    .sums_o (ker_sums)
  );

  pext_mult_result u_result (
    .op_i     (op_i),
    .state_i  (state),
    .sums_i   (ker_sums),
    .imd_i    (imd_q),
    .valid_i  (valid_o),
    .result_o (result_o),
    .set_ov_o (set_ov_o)
  );

endmodule

`default_nettype wire

/* testbench/pext_mult_stim.txt */
// op opa opb stall result ov, all hex, one vector per line
// op: 0 KHM8, 1 KHM16, 2 SMBB16, 3 SMTT16, 4 MUL, 5 MULH
0 80808080 80808080 0 7f7f7f7f 1
0 40404040 40404040 0 20202020 0
0 807fc001 807f40ff 2 7f7ee0ff 1
0 80800000 7f801234 0 817f0000 1
0 10f08005 08f00180 1 0102fffb 0
1 80008000 80008000 0 7fff7fff 1
1 40000001 4000ffff 0 2000ffff 0
1 80007fff 7fff8000 1 80018001 0
1 80001234 80000100 0 7fff0024 1
2 7fff8000 12348000 0 40000000 0
2 0000fffe abcd0003 0 fffffffa 0
2 55557fff aaaa7fff 3 3fff0001 0
3 80000000 7fff0000 0 c0008000 0
3 1234ffff 0010ffff 0 00012340 0
4 00000003 00000005 0 0000000f 0
5 00000003 00000005 0 00000000 0
4 ffffffff 00000002 0 fffffffe 0
5 ffffffff 00000002 2 ffffffff 0
4 80000000 80000000 0 00000000 0
5 80000000 80000000 1 40000000 0
4 7fffffff 7fffffff 0 00000001 0
5 7fffffff 7fffffff 0 3fffffff 0
5 80000000 7fffffff 0 c0000000 0
4 80000000 7fffffff 3 80000000 0
4 ffff0000 0000ffff 0 00010000 0
5 ffff0000 0000ffff 0 ffffffff 0
1 00010002 7fff7fff 0 00000001 0

/* testbench/pext_mult_sva.sv */
////////////////////
// Request, valid and ready protocol assertions
// Bound into the multiplier top level
////////////////////
`timescale 1ns/100ps
`default_nettype none

module pext_mult_sva import pext_mult_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  req_i,
  input logic  ready_i,
  input logic  valid_i,
  input data_t result_i
);

  int fail_count = 0;

  // No result without a request
  valid_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) valid_i |-> req_i
  ) else begin
    $error("valid_o is high while req_i is low");
    fail_count++;
  end

  // Result held under back-pressure
  result_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (valid_i && !ready_i) |=> $stable(result_i)
  ) else begin
    $error("result_o changed while waiting for ready_i");
    fail_count++;
  end

endmodule

bind pext_mult_top pext_mult_sva sva_i (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .req_i    (req_i),
  .ready_i  (ready_i),
  .valid_i  (valid_o),
  .result_i (result_o)
);

`default_nettype wire

/* testbench/tb_clk_gen.sv */
////////////////////
// Testbench clock and reset source
////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 10,
  parameter int unsigned RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_pext_mult.sv */
////////////////////
// Testbench for the packed-SIMD multiplier
// Reads vectors from the stimulus file, drives requests, checks results
////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_pext_mult import pext_mult_pkg::*; ();

  localparam string STIM_FILE = "testbench/pext_mult_stim.txt";
  localparam int    MAX_VEC   = 64;
  localparam int    FIELDS    = 6;
  localparam int    SETTLE_NS = 2;

  logic     clk;
  logic     rst_n;
  logic     req;
  logic     ready;
  pext_op_e op;
  data_t    op_a;
  data_t    op_b;
  logic     valid;
  data_t    result;
  logic     set_ov;

  // One vector is six words: op, A, B, stall, result, overflow
  logic [31:0] stim_mem [FIELDS*MAX_VEC];
  int          num_vec;
  int          max_stall;
  int          cycle_limit;
  int          cycle_cnt;
  int          errors;

  tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(5)) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  pext_mult_top dut_i (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .req_i    (req),
    .op_i     (op),
    .op_a_i   (op_a),
    .op_b_i   (op_b),
    .ready_i  (ready),
    .valid_o  (valid),
    .result_o (result),
    .set_ov_o (set_ov)
  );

  task automatic check_idle(input string name);
    @(negedge clk);
    req  = 1'b0;
    // With req_i low even saturating KHM8 operands leave set_ov_o low
    op   = OP_KHM8;
    op_a = 32'h8080_8080;
    op_b = 32'h8080_8080;
    #SETTLE_NS;
    if (valid !== 1'b0) begin
      $display("[FAIL] %s valid_o expected 0 actual %b", name, valid);
      errors++;
    end
    if (set_ov !== 1'b0) begin
      $display("[FAIL] %s set_ov_o expected 0 actual %b", name, set_ov);
      errors++;
    end
  endtask

  task automatic run_vector(input int v);
    pext_op_e v_op;
    data_t    exp_res;
    logic     exp_ov;
    logic     exp_valid;
    logic     two_cycle;
    logic     accepted;
    int       stall_left;
    int       cyc;
    string    name;
    v_op       = pext_op_e'(stim_mem[FIELDS*v][2:0]);
    stall_left = stim_mem[FIELDS*v+3];
    exp_res    = stim_mem[FIELDS*v+4];
    exp_ov     = stim_mem[FIELDS*v+5][0];
    name       = $sformatf("vec%0d_%s", v, v_op.name());
    // 32x32 products take one extra cycle before valid
    two_cycle  = (v_op == OP_MUL) || (v_op == OP_MULH);
    accepted   = 1'b0;
    cyc        = 0;
    @(negedge clk);
    req  = 1'b1;
    op   = v_op;
    op_a = stim_mem[FIELDS*v+1];
    op_b = stim_mem[FIELDS*v+2];
    while (!accepted) begin
      ready = (stall_left == 0);
      #SETTLE_NS;
      exp_valid = !(two_cycle && cyc == 0);
      if (valid !== exp_valid) begin
        $display("[FAIL] %s valid_o in cycle %0d expected %b actual %b",
                 name, cyc, exp_valid, valid);
        errors++;
      end
      if (valid === 1'b1) begin
        if (result !== exp_res) begin
          $display("[FAIL] %s result_o expected %08h actual %08h", name, exp_res, result);
          errors++;
        end
        if (set_ov !== exp_ov) begin
          $display("[FAIL] %s set_ov_o expected %b actual %b", name, exp_ov, set_ov);
          errors++;
        end
        if (ready) begin
          accepted = 1'b1;
        end else begin
          stall_left--;
        end
      end
      if (!accepted) begin
        @(negedge clk);
        cyc++;
      end
    end
  endtask

  ////////////////////
  // Watchdog
  ////////////////////
  initial begin
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the DUT stopped completing requests", cycle_cnt);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int i;
    int sva_errors;
    req         = 1'b0;
    ready       = 1'b0;
    op          = OP_KHM8;
    op_a        = '0;
    op_b        = '0;
    errors      = 0;
    cycle_limit = 0;
    for (i = 0; i < FIELDS*MAX_VEC; i++) begin
      stim_mem[i] = 'x;
    end
    $readmemh(STIM_FILE, stim_mem);
    num_vec   = 0;
    max_stall = 0;
    while (num_vec < MAX_VEC && !$isunknown(stim_mem[FIELDS*num_vec])) begin
      if (stim_mem[FIELDS*num_vec+3] > max_stall) begin
        max_stall = stim_mem[FIELDS*num_vec+3];
      end
      num_vec++;
    end
    if (num_vec == 0) begin
      $display("No vectors could be read from %s", STIM_FILE);
      errors++;
    end
    cycle_limit = num_vec * (3 + max_stall) + 20;

    wait (rst_n === 1'b1);
    check_idle("reset_idle");
    for (i = 0; i < num_vec; i++) begin
      run_vector(i);
    end
    check_idle("final_idle");

    sva_errors = dut_i.sva_i.fail_count;
    $display("Vectors: %0d, check errors: %0d, assertion errors: %0d",
             num_vec, errors, sva_errors);
    if (errors == 0 && sva_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
